// File: verilog/mips_pkg.sv
//////////////////////////////
// Encodings and control groups for the single-cycle MIPS32 subset
// Loads and stores are matched by opcode[5:3] only, not listed here
//////////////////////////////
package mips_pkg;

  // Data path width
  localparam int XLEN = 32;

  // Supported opcodes
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDI  = 6'b001000,
    OP_ADDIU = 6'b001001,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_SLT  = 6'b101010
  } funct_t;

  // Operation class from the main decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,
    ALUOP_SUB   = 2'b01,
    ALUOP_FUNCT = 2'b10,
    ALUOP_LOGI  = 2'b11
  } aluop_t;

  // Operation actually run by the ALU
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_sel_t;

  //////////////////////////////
  // Control groups
  //////////////////////////////

  // Write-back stage, 2 bits
  typedef struct packed {
    logic memtoreg;
    logic regwrite;
  } wb_ctrl_t;

  // Memory stage, 4 bits
  typedef struct packed {
    logic memread;
    logic memwrite;
    logic branch;
    // Flips the branch test for bne
    logic branch_ne;
  } mem_ctrl_t;

  // Execute stage, 5 bits
  typedef struct packed {
    logic   regdst;
    logic   alusrc;
    // Zero-extend immediate for andi, ori, xori
    logic   zero_ext;
    aluop_t aluop;
  } ex_ctrl_t;

  // Full decoder output, 11 bits
  typedef struct packed {
    wb_ctrl_t  wb;
    mem_ctrl_t mem;
    ex_ctrl_t  ex;
  } ctrl_t;

endpackage

// File: verilog/main_control.sv
//////////////////////////////
// Main decoder, opcode to grouped control bits
// Every unlisted opcode (011xxx too) gives an all-zero nop
//////////////////////////////
`timescale 1ns/1ps

module main_control import mips_pkg::*; (
  input  opcode_t i_opcode,
  output ctrl_t   o_ctrl
);

  always_comb begin
    // Default is a nop, nothing written, no branch
    o_ctrl = '0;
    casez (i_opcode)
      //////////////////////////////
      // Arithmetic and R-type
      //////////////////////////////
      OP_RTYPE: begin
        o_ctrl.wb.regwrite = 1'b1;
        o_ctrl.ex.regdst   = 1'b1;
        o_ctrl.ex.aluop    = ALUOP_FUNCT;
      end
      // addi and addiu share one path, no overflow trap
      OP_ADDI, OP_ADDIU: begin
        o_ctrl.wb.regwrite = 1'b1;
        o_ctrl.ex.alusrc   = 1'b1;
        o_ctrl.ex.aluop    = ALUOP_ADD;
      end
      // Logical immediates
      OP_ANDI, OP_ORI, OP_XORI: begin
        o_ctrl.wb.regwrite = 1'b1;
        o_ctrl.ex.alusrc   = 1'b1;
        o_ctrl.ex.zero_ext = 1'b1;
        o_ctrl.ex.aluop    = ALUOP_LOGI;
      end
      //////////////////////////////
      // Memory access
      //////////////////////////////
      // Whole load group handled as lw
      6'b100???: begin
        o_ctrl.wb.memtoreg = 1'b1;
        o_ctrl.wb.regwrite = 1'b1;
        o_ctrl.mem.memread = 1'b1;
        o_ctrl.ex.alusrc   = 1'b1;
        o_ctrl.ex.aluop    = ALUOP_ADD;
      end
      // Whole store group handled as sw, wb group stays clear
      6'b101???: begin
        o_ctrl.mem.memwrite = 1'b1;
        o_ctrl.ex.alusrc    = 1'b1;
        o_ctrl.ex.aluop     = ALUOP_ADD;
      end
      //////////////////////////////
      // Branches
      //////////////////////////////
      // Compare by subtraction, zero flag decides
      OP_BEQ: begin
        o_ctrl.mem.branch = 1'b1;
        o_ctrl.ex.aluop   = ALUOP_SUB;
      end
      OP_BNE: begin
        o_ctrl.mem.branch    = 1'b1;
        o_ctrl.mem.branch_ne = 1'b1;
        o_ctrl.ex.aluop      = ALUOP_SUB;
      end
      default: begin
        o_ctrl = '0;
      end
    endcase
  end

endmodule

// File: verilog/alu_control.sv
//////////////////////////////
// ALU operation select
// Unknown funct codes fall back to add
//////////////////////////////
`timescale 1ns/1ps

module alu_control import mips_pkg::*; (
  input  aluop_t   i_aluop,
  input  funct_t   i_funct,
  // opcode[1:0], picks the logical immediate op
  input  logic [1:0] i_op_low,
  output alu_sel_t o_alu_sel
);

  always_comb begin
    o_alu_sel = ALU_ADD;
    case (i_aluop)
      ALUOP_ADD: o_alu_sel = ALU_ADD;
      ALUOP_SUB: o_alu_sel = ALU_SUB;
      // R-type, signed and unsigned forms run the same
      ALUOP_FUNCT: begin
        case (i_funct)
          FN_ADD, FN_ADDU: o_alu_sel = ALU_ADD;
          FN_SUB, FN_SUBU: o_alu_sel = ALU_SUB;
          FN_AND:          o_alu_sel = ALU_AND;
          FN_OR:           o_alu_sel = ALU_OR;
          FN_XOR:          o_alu_sel = ALU_XOR;
          FN_SLT:          o_alu_sel = ALU_SLT;
          default:         o_alu_sel = ALU_ADD;
        endcase
      end
      // andi 00, ori 01, xori 10
      ALUOP_LOGI: begin
        case (i_op_low)
          2'b01:   o_alu_sel = ALU_OR;
          2'b10:   o_alu_sel = ALU_XOR;
          default: o_alu_sel = ALU_AND;
        endcase
      end
      default: o_alu_sel = ALU_ADD;
    endcase
  end

endmodule

// File: verilog/alu.sv
//////////////////////////////
// 32-bit ALU, purely combinational
// Arithmetic wraps, no overflow flag or trap
//////////////////////////////
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  alu_sel_t        i_sel,
  output logic [XLEN-1:0] o_result,
  output logic            o_zero
);

  // Signed compare for slt
  logic a_lt_b;

  assign a_lt_b = $signed(i_a) < $signed(i_b);

  always_comb begin
    case (i_sel)
      ALU_ADD: o_result = i_a + i_b;
      // Also the compare for beq and bne
      ALU_SUB: o_result = i_a - i_b;
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      // 1 or 0 in the low bit
      ALU_SLT: o_result = {{(XLEN-1){1'b0}}, a_lt_b};
      default: o_result = i_a + i_b;
    endcase
  end

  // Zero flag feeds the branch decision
  assign o_zero = (o_result == '0);

endmodule

// File: verilog/reg_file.sv
//////////////////////////////
// 32 x XLEN registers, 2 read ports, 1 write port
// Reads are combinational, writes land at the clock edge
//////////////////////////////
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [4:0]      i_ra1,
  input  logic [4:0]      i_ra2,
  output logic [XLEN-1:0] o_rd1,
  output logic [XLEN-1:0] o_rd2,
  input  logic            i_we,
  input  logic [4:0]      i_wa,
  input  logic [XLEN-1:0] i_wd
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_wa != 5'd0)) begin
      // $zero never takes a write
      regs[i_wa] <= i_wd;
    end
  end

  // Register 0 forced to zero on read
  assign o_rd1 = (i_ra1 == 5'd0) ? '0 : regs[i_ra1];
  assign o_rd2 = (i_ra2 == 5'd0) ? '0 : regs[i_ra2];

endmodule

// File: verilog/data_mem.sv
//////////////////////////////
// Word data memory, DEPTH must be a power of two, at least 2
// Low two address bits ignored, upper bits wrap modulo DEPTH
//////////////////////////////
`timescale 1ns/1ps

module data_mem import mips_pkg::*; #(
  parameter int DEPTH = 64
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_wdata,
  input  mem_ctrl_t       i_mem,
  output logic [XLEN-1:0] o_rdata
);

  localparam int AW = $clog2(DEPTH);

  logic [XLEN-1:0] mem [DEPTH];
  // Word index, byte offset dropped
  logic [AW-1:0]   idx;

  assign idx = i_addr[AW+1:2];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (i_mem.memwrite) begin
      mem[idx] <= i_wdata;
    end
  end

  // Read data only on a load, zero otherwise
  assign o_rdata = i_mem.memread ? mem[idx] : '0;

endmodule

// File: verilog/pc_unit.sv
//////////////////////////////
// Program counter, next pc picked from pc+4 or branch target
// No jumps, branch offset is a word count
//////////////////////////////
`timescale 1ns/1ps

module pc_unit import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  mem_ctrl_t       i_mem,
  input  logic            i_zero,
  // Sign-extended branch offset
  input  logic [XLEN-1:0] i_imm,
  output logic [XLEN-1:0] o_pc
);

  logic            taken;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] pc_br;

  // beq takes on zero, bne on not zero
  assign taken  = i_mem.branch & (i_zero ^ i_mem.branch_ne);
  assign pc_seq = o_pc + 32'd4;
  assign pc_br  = pc_seq + {i_imm[XLEN-3:0], 2'b00};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc <= '0;
    end else begin
      o_pc <= taken ? pc_br : pc_seq;
    end
  end

endmodule

// File: verilog/mips_core.sv
//////////////////////////////
// Single-cycle MIPS32 subset core, one instruction per clock
// i_instr must follow o_pc combinationally, no handshake
//////////////////////////////
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [XLEN-1:0] i_instr,
  output logic [XLEN-1:0] o_pc,
  output logic            o_wb_we,
  output logic [4:0]      o_wb_addr,
  output logic [XLEN-1:0] o_wb_data
);

  // Instruction fields
  opcode_t         opcode;
  funct_t          funct;
  logic [4:0]      rs;
  logic [4:0]      rt;
  logic [4:0]      rd;
  logic [15:0]     imm16;
  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] imm_ext;

  // Control and data path
  ctrl_t           ctrl;
  alu_sel_t        alu_sel;
  logic [XLEN-1:0] rd1;
  logic [XLEN-1:0] rd2;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_res;
  logic            alu_zero;
  logic [XLEN-1:0] mem_rdata;

  assign opcode = opcode_t'(i_instr[31:26]);
  assign funct  = funct_t'(i_instr[5:0]);
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];
  assign rd     = i_instr[15:11];
  assign imm16  = i_instr[15:0];

  // Sign extend for arithmetic, memory and branches
  assign imm_sext = {{(XLEN-16){imm16[15]}}, imm16};
  assign imm_ext  = ctrl.ex.zero_ext ? {{(XLEN-16){1'b0}}, imm16} : imm_sext;

  main_control u_main_control (
    .i_opcode (opcode),
    .o_ctrl   (ctrl)
  );

  alu_control u_alu_control (
    .i_aluop   (ctrl.ex.aluop),
    .i_funct   (funct),
    .i_op_low  (i_instr[27:26]),
    .o_alu_sel (alu_sel)
  );

  reg_file u_reg_file (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_ra1 (rs),
    .i_ra2 (rt),
    .o_rd1 (rd1),
    .o_rd2 (rd2),
    .i_we  (ctrl.wb.regwrite),
    .i_wa  (o_wb_addr),
    .i_wd  (o_wb_data)
  );

  // Operand B is rt or the extended immediate
  assign alu_b = ctrl.ex.alusrc ? imm_ext : rd2;

  alu u_alu (
    .i_a      (rd1),
    .i_b      (alu_b),
    .i_sel    (alu_sel),
    .o_result (alu_res),
    .o_zero   (alu_zero)
  );

  data_mem #(
    .DEPTH (DMEM_DEPTH)
  ) u_data_mem (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_addr  (alu_res),
    .i_wdata (rd2),
    .i_mem   (ctrl.mem),
    .o_rdata (mem_rdata)
  );

  pc_unit u_pc_unit (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_mem  (ctrl.mem),
    .i_zero (alu_zero),
    .i_imm  (imm_sext),
    .o_pc   (o_pc)
  );

  //////////////////////////////
  // Write-back
  //////////////////////////////
  // rd for R-type, rt for immediates and loads
  assign o_wb_we   = ctrl.wb.regwrite;
  assign o_wb_addr = ctrl.ex.regdst ? rd : rt;
  assign o_wb_data = ctrl.wb.memtoreg ? mem_rdata : alu_res;

endmodule

// File: tb/mips_core_sva.sv
//////////////////////////////
// Checks on pc, control and write-back, bound into mips_core
// Failures are counted in fail_count for the testbench
//////////////////////////////
`timescale 1ns/1ps

module mips_core_sva import mips_pkg::*; (
  input logic            i_clk,
  input logic            i_rst,
  input logic [XLEN-1:0] i_pc,
  input logic            i_wb_we,
  input logic [4:0]      i_wb_addr,
  input ctrl_t           i_ctrl
);

  int fail_count = 0;

  // Fetch restarts at address zero
  a_pc_reset: assert property (@(posedge i_clk) i_rst |=> (i_pc == '0))
    else begin
      fail_count++;
      $error("o_pc is not zero after reset");
    end

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) (i_pc[1:0] == 2'b00))
    else begin
      fail_count++;
      $error("o_pc is not word aligned");
    end

  // A store never writes a register
  a_one_write: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_wb_we && i_ctrl.mem.memwrite))
    else begin
      fail_count++;
      $error("register and memory write requested together");
    end

  // ALU results never aimed at $zero, loads are left out
  a_no_zero_dest: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_wb_we && !i_ctrl.wb.memtoreg) |-> (i_wb_addr != 5'd0))
    else begin
      fail_count++;
      $error("ALU write-back aimed at register 0");
    end

endmodule

bind mips_core mips_core_sva u_sva (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_pc      (o_pc),
  .i_wb_we   (o_wb_we),
  .i_wb_addr (o_wb_addr),
  .i_ctrl    (ctrl)
);

// File: tb/tb_mips_core.sv
//////////////////////////////
// Runs the program from tb/mips_cases.txt on the core, one line per cycle
// Program must sit below address 0x100, forward branches only
// Outputs checked at the falling edge, inputs driven at the rising edge
//////////////////////////////
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

  localparam int              CLK_PERIOD = 40;
  localparam int              RST_CYCLES = 10;
  localparam int              PROG_WORDS = 64;
  // Opcode 111111 decodes as a nop
  localparam logic [XLEN-1:0] NOP_WORD   = 32'hfc00_0000;
  localparam logic [XLEN-1:0] END_PC     = 32'hffff_ffff;

  logic            i_clk;
  logic            i_rst;
  logic [XLEN-1:0] i_instr;
  logic [XLEN-1:0] o_pc;
  logic            o_wb_we;
  logic [4:0]      o_wb_addr;
  logic [XLEN-1:0] o_wb_data;

  // Program image and expected results, one slot per word address
  logic            case_valid [PROG_WORDS];
  logic [XLEN-1:0] case_instr [PROG_WORDS];
  logic            exp_we     [PROG_WORDS];
  logic [4:0]      exp_addr   [PROG_WORDS];
  logic [XLEN-1:0] exp_data   [PROG_WORDS];
  logic [XLEN-1:0] exp_next   [PROG_WORDS];

  int   n_cases;
  int   n_checks;
  int   n_errors;
  logic loaded;

  mips_core #(
    .DMEM_DEPTH (64)
  ) DUT (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_instr   (i_instr),
    .o_pc      (o_pc),
    .o_wb_we   (o_wb_we),
    .o_wb_addr (o_wb_addr),
    .o_wb_data (o_wb_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Slot of an address, -1 when no case line covers it
  function automatic int slot_of(input logic [XLEN-1:0] addr);
    if (addr[XLEN-1:8] !== '0 || addr[1:0] !== 2'b00) begin
      return -1;
    end
    if (case_valid[addr[7:2]] !== 1'b1) begin
      return -1;
    end
    return int'(addr[7:2]);
  endfunction

  // Instruction memory model, unlisted addresses give the nop
  function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
    int s;
    s = slot_of(addr);
    return (s < 0) ? NOP_WORD : case_instr[s];
  endfunction

  //////////////////////////////
  // Cases file
  //////////////////////////////
  task automatic load_cases();
    int                fd;
    int                code;
    logic [8*128-1:0]  line;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   ins;
    logic [XLEN-1:0]   we;
    logic [XLEN-1:0]   rg;
    logic [XLEN-1:0]   dt;
    logic [XLEN-1:0]   nx;
    for (int i = 0; i < PROG_WORDS; i++) begin
      case_valid[i] = 1'b0;
    end
    fd = $fopen("tb/mips_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the cases file tb/mips_cases.txt");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        code = $fgets(line, fd);
        // Comment and blank lines do not scan as six fields
        if (code > 0 && $sscanf(line, "%h %h %h %h %h %h", a, ins, we, rg, dt, nx) == 6) begin
          if (a[XLEN-1:8] != '0 || a[1:0] != 2'b00) begin
            $display("cases file address %h lies outside the program space", a);
            n_errors++;
          end else begin
            case_valid[a[7:2]] = 1'b1;
            case_instr[a[7:2]] = ins;
            exp_we[a[7:2]]     = we[0];
            exp_addr[a[7:2]]   = rg[4:0];
            exp_data[a[7:2]]   = dt;
            exp_next[a[7:2]]   = nx;
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Write-back of the instruction at pc against its case line
  task automatic check_writeback(input logic [XLEN-1:0] pc, input int s);
    n_checks++;
    assert (o_wb_we === exp_we[s]) else begin
      $display("error %h: o_wb_we expected %b, actual %b", pc, exp_we[s], o_wb_we);
      n_errors++;
    end
    // Register and data only mean something on a write
    if (exp_we[s]) begin
      n_checks += 2;
      assert (o_wb_addr === exp_addr[s]) else begin
        $display("error %h: o_wb_addr expected %h, actual %h", pc, exp_addr[s], o_wb_addr);
        n_errors++;
      end
      assert (o_wb_data === exp_data[s]) else begin
        $display("error %h: o_wb_data expected %h, actual %h", pc, exp_data[s], o_wb_data);
        n_errors++;
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    logic [XLEN-1:0] pc_now;
    logic [XLEN-1:0] pc_next;
    int              s;
    bit              done;
    i_rst    = 1'b1;
    i_instr  = NOP_WORD;
    n_cases  = 0;
    n_checks = 0;
    n_errors = 0;
    loaded   = 1'b0;
    done     = 1'b0;
    load_cases();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge i_clk);
    i_rst   <= 1'b0;
    i_instr <= fetch_word('0);
    @(negedge i_clk);
    n_checks++;
    assert (o_pc === '0) else begin
      $display("error reset: o_pc expected %h, actual %h", 32'h0, o_pc);
      n_errors++;
    end
    while (!done) begin
      pc_now = o_pc;
      s      = slot_of(pc_now);
      if (s < 0) begin
        $display("o_pc %h has no line in the cases file, run stopped", pc_now);
        n_errors++;
        done = 1'b1;
      end else begin
        check_writeback(pc_now, s);
        if (exp_next[s] === END_PC) begin
          done = 1'b1;
        end else begin
          pc_next = exp_next[s];
          @(posedge i_clk);
          i_instr <= fetch_word(pc_next);
          @(negedge i_clk);
          n_checks++;
          assert (o_pc === pc_next) else begin
            $display("error %h: next pc expected %h, actual %h", pc_now, pc_next, o_pc);
            n_errors++;
          end
        end
      end
    end
    // Bound assertion failures count too
    n_errors += DUT.u_sva.fail_count;
    $display("cases %0d, checks %0d, errors %0d", n_cases, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, four cycles per case plus reset margin
  initial begin
    wait (loaded === 1'b1);
    #((n_cases * 4 + 20) * CLK_PERIOD);
    $display("timeout: the program never reached its last line after %0d cycles",
             n_cases * 4 + 20);
    $display("Test failed");
    $finish;
  end

endmodule

// File: tb/mips_cases.txt
# addr instr we reg data next_pc, all hex
# reg and data are ignored when we is 0, next_pc ffffffff ends the run
00000000 20010005 1 01 00000005 00000004
00000004 2402fffd 1 02 fffffffd 00000008
00000008 00221820 1 03 00000002 0000000c
0000000c 00412022 1 04 fffffff8 00000010
00000010 0041282a 1 05 00000001 00000014
00000014 0022302a 1 06 00000000 00000018
00000018 3047f0f0 1 07 0000f0f0 0000001c
0000001c 34288000 1 08 00008005 00000020
00000020 3849ffff 1 09 ffff0002 00000024
00000024 00e85024 1 0a 00008000 00000028
00000028 00e85825 1 0b 0000f0f5 0000002c
0000002c 00e96026 1 0c fffff0f2 00000030
00000030 ac090010 0 00 00000000 00000034
00000034 8c0d0010 1 0d ffff0002 00000038
00000038 8c000010 1 00 ffff0002 0000003c
0000003c 00017020 1 0e 00000005 00000040
00000040 10210001 0 00 00000000 00000048
00000044 200f0077 1 0f 00000077 00000048
00000048 142e0003 0 00 00000000 0000004c
0000004c 60e70042 0 00 00000000 00000050
00000050 14230001 0 00 00000000 00000058
00000054 200f0088 1 0f 00000088 00000058
00000058 01ae8020 1 10 ffff0007 ffffffff

// File: filelist.f
verilog/mips_pkg.sv
verilog/main_control.sv
verilog/alu_control.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/data_mem.sv
verilog/pc_unit.sv
verilog/mips_core.sv
tb/mips_core_sva.sv
tb/tb_mips_core.sv
